//--- tests/mem_2port_tests.txt
// columns in hex: port op len adr dat_w expected_dat_r
// op 0 read 1 write 3 add 4 and 5 or / len 0 word 1 byte 2 half
0 1 0 0010 12345678 00000000
0 0 0 0010 00000000 12345678
0 1 1 0011 000000ab 00000000
0 0 0 0010 00000000 1234ab78
0 0 1 0013 00000000 00000012
0 1 2 0012 0000cafe 00000000
0 0 2 0012 00000000 0000cafe
0 0 0 0010 00000000 cafeab78
0 1 0 0040 11112222 00000000
0 1 0 0440 33334444 00000000
0 0 0 0040 00000000 33334444
0 1 0 8040 55556666 00000000
0 0 0 0440 00000000 55556666
0 1 0 0080 0000f0f0 00000000
0 5 0 0080 00000f0f 0000f0f0
0 0 0 0080 00000000 0000ffff
0 3 0 0080 0000ff01 0000ffff
0 0 0 0080 00000000 0001ff00
0 4 0 0080 0000f0ff 0001ff00
0 0 0 0080 00000000 0000f000
0 0 1 0011 00000000 000000ab
0 0 2 0042 00000000 00005555
0 0 1 0041 00000000 00000066
0 0 2 0010 00000000 0000ab78
1 1 0 0200 a5a5a5a5 00000000
1 0 0 0200 00000000 a5a5a5a5
1 1 1 0202 0000003c 00000000
1 0 0 0200 00000000 a53ca5a5
1 0 2 0202 00000000 0000a53c
1 0 1 0201 00000000 000000a5
1 1 0 0204 80000000 00000000
1 3 0 0204 80000001 80000000
1 0 0 0204 00000000 00000001
1 5 0 0604 f0000000 00000001
1 0 0 0204 00000000 f0000001

//--- src.f
rtl/mem_pkg.sv
rtl/port_arbiter_fsm.sv
rtl/access_delay_timer.sv
rtl/amo_datapath.sv
rtl/mem_word_array.sv
rtl/mem_2port.sv
tests/mem_2port_props.sv
tests/tb_mem_2port.sv

//--- Bender.yml
package:
  name: mem_2port

sources:
  - rtl/mem_pkg.sv
  - rtl/port_arbiter_fsm.sv
  - rtl/access_delay_timer.sv
  - rtl/amo_datapath.sv
  - rtl/mem_word_array.sv
  - rtl/mem_2port.sv
  - target: test
    files:
      - tests/mem_2port_props.sv
      - tests/tb_mem_2port.sv

//--- tests/tb_mem_2port.sv
/*
 * Testbench for the two-port memory. Replays the request records of the data
 * file on both Wishbone ports and checks every response and the idle latency.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_2port
  import mem_pkg::*;
();

  localparam int WAIT_CYC = 3;
  localparam int FIELDS   = 6;   // port op len adr dat_w expected
  localparam int MAX_RECS = 64;

  logic                   clk;
  logic                   rst;
  logic [1:0]             cyc;
  logic [1:0]             stb;
  mem_op_e                op [2];
  mem_len_e               len [2];
  logic [1:0][ADDR_W-1:0] adr;
  logic [1:0][DATA_W-1:0] dat_w;
  wire  [1:0]             ack;
  wire  [1:0][DATA_W-1:0] dat_r;

  logic [31:0] recs [FIELDS*MAX_RECS];
  int          num_recs;
  int          limit;
  int          cycles = 0;
  logic [31:0] lfsr_q;
  logic [1:0]  pending;   // request seen by the DUT, no ack yet
  logic [1:0]  timed;     // request started against an idle memory
  logic [1:0]  ack_seen;
  int          edges [2];
  int          lat_checks;

  mem_2port mem_2port_i (
    .clk         (clk),
    .rst         (rst),
    .wait_cycles (WAIT_W'(WAIT_CYC)),
    .cyc0        (cyc[0]),
    .stb0        (stb[0]),
    .op0         (op[0]),
    .len0        (len[0]),
    .adr0        (adr[0]),
    .dat_w0      (dat_w[0]),
    .ack0        (ack[0]),
    .dat_r0      (dat_r[0]),
    .cyc1        (cyc[1]),
    .stb1        (stb[1]),
    .op1         (op[1]),
    .len1        (len[1]),
    .adr1        (adr[1]),
    .dat_w1      (dat_w[1]),
    .ack1        (ack[1]),
    .dat_r1      (dat_r[1])
  );

  always #20 clk = ~clk;

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------
  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_gap(output int gap);
    logic b0;
    logic b1;
    b0     = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    b1     = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    gap    = {b1, b0};
  endtask

  // one port's records in file order, inputs change on falling edges
  task automatic replay_port(input int p);
    int r;
    int base;
    int gap;
    for (r = 0; r < num_recs; r++)
    begin
      base = r * FIELDS;
      if (recs[base] == p)
      begin
        draw_gap(gap);
        repeat (gap) @(negedge clk);
        op[p]    = mem_op_e'(recs[base+1][2:0]);
        len[p]   = mem_len_e'(recs[base+2][1:0]);
        adr[p]   = recs[base+3][ADDR_W-1:0];
        dat_w[p] = recs[base+4];
        cyc[p]   = 1'b1;
        stb[p]   = 1'b1;
        do
          @(negedge clk);
        while (!ack[p]);
        check_value(dat_r[p], recs[base+5],
                    $sformatf("port %0d record %0d dat_r", p, r));
        cyc[p] = 1'b0;
        stb[p] = 1'b0;
      end
    end
  endtask

  // ------------------------------------------------------------------------
  // latency and spurious ack monitor
  // ------------------------------------------------------------------------
  always @(posedge clk)
  begin
    if (!rst)
    begin
      for (int p = 0; p < 2; p++)
      begin
        if (pending[p])
          edges[p] = edges[p] + 1;
        else if (cyc[p] && stb[p])
        begin
          pending[p] = 1'b1;
          edges[p]   = 1;  // grant edge
          timed[p]   = !(cyc[1-p] && stb[1-p]) && !ack_seen[1-p];
        end
      end
    end
  end

  always @(negedge clk)
  begin
    for (int p = 0; p < 2; p++)
    begin
      ack_seen[p] = ack[p];
      if (ack[p])
      begin
        check_value(pending[p], 1'b1, $sformatf("port %0d ack without request", p));
        if (timed[p])
        begin
          check_value(edges[p], WAIT_CYC + 2, $sformatf("port %0d ack latency", p));
          lat_checks = lat_checks + 1;
        end
        pending[p] = 1'b0;
      end
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= limit)
    begin
      $display("timeout, requests still unanswered after %0d cycles", cycles);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation timeout");
    end
  end

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------
  initial
  begin
    clk        = 1'b0;
    rst        = 1'b1;
    cyc        = '0;
    stb        = '0;
    adr        = '0;
    dat_w      = '0;
    pending    = '0;
    timed      = '0;
    ack_seen   = '0;
    lat_checks = 0;
    lfsr_q     = 32'h80cf;
    for (int p = 0; p < 2; p++)
    begin
      op[p]    = OP_READ;
      len[p]   = LEN_WORD;
      edges[p] = 0;
    end
    limit = 100;
    $readmemh("tests/mem_2port_tests.txt", recs);
    num_recs = 0;
    while (num_recs < MAX_RECS && !$isunknown(recs[num_recs*FIELDS]))
      num_recs = num_recs + 1;
    limit = 2 * num_recs * (WAIT_CYC + 6) + 100;

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    fork
      replay_port(0);
      replay_port(1);
    join
    @(negedge clk);  // monitor has seen the last ack

    check_value(num_recs > 0, 1'b1, "records read from the data file");
    check_value(lat_checks > 0, 1'b1, "requests timed against an idle memory");
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/mem_2port_props.sv
/*
 * Concurrent checks on the Wishbone handshake and the round-robin grant,
 * bound into the mem_2port top level.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_2port_props
  import mem_pkg::*;
(
  input logic              clk,
  input logic              rst,
  input logic              cyc0,
  input logic              stb0,
  input mem_op_e           op0,
  input mem_len_e          len0,
  input logic [ADDR_W-1:0] adr0,
  input logic [DATA_W-1:0] dat_w0,
  input logic              ack0,
  input logic              cyc1,
  input logic              stb1,
  input mem_op_e           op1,
  input mem_len_e          len1,
  input logic [ADDR_W-1:0] adr1,
  input logic [DATA_W-1:0] dat_w1,
  input logic              ack1,
  input logic              sel,
  input logic              start
);

  logic last_acked;

  always_ff @(posedge clk)
  begin
    if (rst)
      last_acked <= 1'b1;  // port 0 wins the first tie
    else if (ack0)
      last_acked <= 1'b0;
    else if (ack1)
      last_acked <= 1'b1;
  end

  ack0_pulse: assert property (@(posedge clk) disable iff (rst) ack0 |=> !ack0)
    else $error("ack0 high for two cycles");
  ack1_pulse: assert property (@(posedge clk) disable iff (rst) ack1 |=> !ack1)
    else $error("ack1 high for two cycles");
  ack_onehot: assert property (@(posedge clk) disable iff (rst) !(ack0 && ack1))
    else $error("ack0 and ack1 high together");

  // fields may only move once ack has been seen
  req0_stable: assert property (@(posedge clk) disable iff (rst)
    (cyc0 && stb0 && !ack0) |=> (ack0 || (stb0 && $stable({op0, len0, adr0, dat_w0}))))
    else $error("port 0 request changed before ack");
  req1_stable: assert property (@(posedge clk) disable iff (rst)
    (cyc1 && stb1 && !ack1) |=> (ack1 || (stb1 && $stable({op1, len1, adr1, dat_w1}))))
    else $error("port 1 request changed before ack");

  rr_grant: assert property (@(posedge clk) disable iff (rst)
    (start && cyc0 && stb0 && cyc1 && stb1) |=> (sel != last_acked))
    else $error("tie granted to the port served last");

endmodule

bind mem_2port mem_2port_props props_i (.*);

`default_nettype wire

//--- rtl/mem_2port.sv
/*
 * Two-port test memory with Wishbone classic slave ports. One request is
 * served at a time, after wait_cycles wait states, with round-robin grant.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_2port
  import mem_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [WAIT_W-1:0] wait_cycles,

  // port 0
  input  logic              cyc0,
  input  logic              stb0,
  input  mem_op_e           op0,
  input  mem_len_e          len0,
  input  logic [ADDR_W-1:0] adr0,
  input  logic [DATA_W-1:0] dat_w0,
  output logic              ack0,
  output logic [DATA_W-1:0] dat_r0,

  // port 1
  input  logic              cyc1,
  input  logic              stb1,
  input  mem_op_e           op1,
  input  mem_len_e          len1,
  input  logic [ADDR_W-1:0] adr1,
  input  logic [DATA_W-1:0] dat_w1,
  output logic              ack1,
  output logic [DATA_W-1:0] dat_r1
);

  logic                  sel;
  logic                  start;
  logic                  access;
  logic                  expired;
  logic                  write;
  mem_op_e               op_m;
  mem_len_e              len_m;
  logic [ADDR_W-1:0]     adr_m;
  logic [DATA_W-1:0]     dat_w_m;
  logic [WORD_IDX_W-1:0] word_idx;
  lane_t                 lanes;
  logic [DATA_W-1:0]     new_word;
  logic [DATA_W-1:0]     old_word;
  logic [DATA_W-1:0]     resp;

  // ------------------------------------------------------------------------
  // control
  // ------------------------------------------------------------------------
  port_arbiter_fsm arb_i (
    .clk     (clk),
    .rst     (rst),
    .stb0    (stb0),
    .stb1    (stb1),
    .cyc0    (cyc0),
    .cyc1    (cyc1),
    .expired (expired),
    .sel     (sel),
    .start   (start),
    .access  (access),
    .ack0    (ack0),
    .ack1    (ack1)
  );

  access_delay_timer timer_i (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .wait_cycles (wait_cycles),
    .expired     (expired)
  );

  // ------------------------------------------------------------------------
  // granted request into the datapath
  // ------------------------------------------------------------------------
  assign op_m    = sel ? op1 : op0;
  assign len_m   = sel ? len1 : len0;
  assign adr_m   = sel ? adr1 : adr0;
  assign dat_w_m = sel ? dat_w1 : dat_w0;
  assign write   = (op_m != OP_READ);  // AMOs write back too

  amo_datapath dp_i (
    .op       (op_m),
    .len      (len_m),
    .adr      (adr_m),
    .wdata    (dat_w_m),
    .old_word (old_word),
    .word_idx (word_idx),
    .lanes    (lanes),
    .new_word (new_word),
    .resp     (resp)
  );

  mem_word_array array_i (
    .clk      (clk),
    .access   (access),
    .write    (write),
    .word_idx (word_idx),
    .lanes    (lanes),
    .new_word (new_word),
    .old_word (old_word)
  );

  // response data, qualified by the matching ack
  always_ff @(posedge clk)
  begin
    if (access)
    begin
      dat_r0 <= resp;
      dat_r1 <= resp;
    end
  end

endmodule

`default_nettype wire

//--- rtl/mem_word_array.sv
/*
 * Word-wide storage with per-byte write enables. Read is asynchronous,
 * writes land on the access edge.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_word_array
  import mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  access,
  input  logic                  write,
  input  logic [WORD_IDX_W-1:0] word_idx,
  input  lane_t                 lanes,
  input  logic [DATA_W-1:0]     new_word,
  output logic [DATA_W-1:0]     old_word
);

  logic [DATA_W-1:0] mem [MEM_BYTES/4];  // 256 words

  always_ff @(posedge clk)
  begin
    if (access && write)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (lanes[i])
          mem[word_idx][8*i +: 8] <= new_word[8*i +: 8];
      end
    end
  end

  assign old_word = mem[word_idx];  // old value for reads and AMOs

endmodule

`default_nettype wire

//--- rtl/amo_datapath.sv
/*
 * Combinational request datapath: word index, lane mask, aligned write
 * word, AMO result and the right-aligned response for the granted request.
 */
`timescale 1ns/1ps
`default_nettype none

module amo_datapath
  import mem_pkg::*;
(
  input  mem_op_e                 op,
  input  mem_len_e                len,
  input  logic [ADDR_W-1:0]       adr,
  input  logic [DATA_W-1:0]       wdata,
  input  logic [DATA_W-1:0]       old_word,
  output logic [WORD_IDX_W-1:0]   word_idx,
  output lane_t                   lanes,
  output logic [DATA_W-1:0]       new_word,
  output logic [DATA_W-1:0]       resp
);

  logic              is_amo;
  logic              is_read;
  logic [1:0]        off;
  logic [4:0]        shamt;   // bit shift for the first lane
  logic [DATA_W-1:0] old_sh;

  assign is_amo  = op inside {OP_AMO_ADD, OP_AMO_AND, OP_AMO_OR};
  assign is_read = (op == OP_READ);

  // upper address bits dropped, so addresses alias every 1 KiB
  assign word_idx = adr[WORD_IDX_W+1:2];

  // AMOs always work on the whole word
  assign off   = is_amo ? 2'd0 : lane_offset(len, adr[1:0]);
  assign lanes = is_amo ? lane_t'(4'b1111) : lane_mask(len, off);
  assign shamt = {off, 3'b000};

  // ------------------------------------------------------------------------
  // write word
  // ------------------------------------------------------------------------
  always_comb
  begin
    case (op)
      OP_AMO_ADD: new_word = old_word + wdata;
      OP_AMO_AND: new_word = old_word & wdata;
      OP_AMO_OR:  new_word = old_word | wdata;
      default:    new_word = wdata << shamt;  // lanes outside the mask ignored
    endcase
  end

  // ------------------------------------------------------------------------
  // response
  // ------------------------------------------------------------------------
  assign old_sh = old_word >> shamt;

  always_comb
  begin
    if (!is_read && !is_amo)
      resp = '0;  // writes answer with zero
    else if (is_amo)
      resp = old_word;
    else
    begin
      case (len)
        LEN_BYTE: resp = {24'b0, old_sh[7:0]};
        LEN_HALF: resp = {16'b0, old_sh[15:0]};
        default:  resp = old_sh;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/access_delay_timer.sv
/*
 * Wait-state counter. Loaded on start, counts down to zero and flags
 * expired so the arbiter can perform the access.
 */
`timescale 1ns/1ps
`default_nettype none

module access_delay_timer
  import mem_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic [WAIT_W-1:0] wait_cycles,
  output logic              expired
);

  logic [WAIT_W-1:0] count_q;

  always_ff @(posedge clk)
  begin
    if (rst)
      count_q <= '0;
    else if (start)
      count_q <= wait_cycles;
    else if (count_q != '0)
      count_q <= count_q - 1'b1;  // stops at zero
  end

  // a fresh start always hides a stale zero count
  assign expired = (count_q == '0) && !start;

endmodule

`default_nettype wire

//--- rtl/port_arbiter_fsm.sv
/*
 * Round-robin arbiter and access sequencer for the two request ports.
 * Grants one request, waits on the delay timer, then acks for one cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module port_arbiter_fsm (
  input  logic clk,
  input  logic rst,
  input  logic stb0,
  input  logic stb1,
  input  logic cyc0,
  input  logic cyc1,
  input  logic expired,
  output logic sel,     // granted port
  output logic start,   // load pulse for the delay timer
  output logic access,  // memory access this cycle
  output logic ack0,
  output logic ack1
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    ACK
  } state_e;

  state_e state_q;
  logic   sel_q;
  logic   last_q;   // port served most recently
  logic   ack0_q;
  logic   ack1_q;
  logic   req0;
  logic   req1;
  logic   pick;

  assign req0 = cyc0 & stb0;
  assign req1 = cyc1 & stb1;

  // both waiting: the port not served last goes next
  assign pick = (req0 && req1) ? ~last_q : req1;

  // ack cycle also arbitrates for the next request
  assign start  = ((state_q == IDLE) || (state_q == ACK)) && (req0 || req1);
  assign access = (state_q == WAIT) && expired;

  // ------------------------------------------------------------------------
  // state and grant registers
  // ------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= IDLE;
      sel_q   <= 1'b0;
      last_q  <= 1'b1;  // port 0 first out of reset
      ack0_q  <= 1'b0;
      ack1_q  <= 1'b0;
    end
    else
    begin
      ack0_q <= 1'b0;  // ack is a single-cycle pulse
      ack1_q <= 1'b0;
      case (state_q)
        // master samples ack in ACK, new request seen from next edge on
        IDLE, ACK:
        begin
          if (start)
          begin
            state_q <= WAIT;
            sel_q   <= pick;
            last_q  <= pick;
          end
          else
            state_q <= IDLE;
        end
        WAIT:
        begin
          if (expired)
          begin
            state_q <= ACK;
            ack0_q  <= ~sel_q;
            ack1_q  <= sel_q;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign sel  = sel_q;
  assign ack0 = ack0_q;
  assign ack1 = ack1_q;

endmodule

`default_nettype wire

//--- rtl/mem_pkg.sv
/*
 * Shared sizes, request encodings and byte-lane helpers for the two-port
 * test memory. Modules pull these in with a wildcard import in their header.
 */
`default_nettype none

package mem_pkg;

  // ------------------------------------------------------------------------
  // sizes
  // ------------------------------------------------------------------------
  localparam int MEM_BYTES  = 1024;
  localparam int ADDR_W     = 16;
  localparam int DATA_W     = 32;
  localparam int WORD_IDX_W = $clog2(MEM_BYTES) - 2;  // address bits 9..2
  localparam int WAIT_W     = 4;

  // request type field, code 2 left unused
  typedef enum logic [2:0] {
    OP_READ    = 3'd0,
    OP_WRITE   = 3'd1,
    OP_AMO_ADD = 3'd3,
    OP_AMO_AND = 3'd4,
    OP_AMO_OR  = 3'd5
  } mem_op_e;

  typedef enum logic [1:0] {
    LEN_WORD = 2'd0,  // full 32 bits
    LEN_BYTE = 2'd1,
    LEN_HALF = 2'd2
  } mem_len_e;

  typedef logic [3:0] lane_t;

  // ------------------------------------------------------------------------
  // lane helpers
  // ------------------------------------------------------------------------

  // first byte lane touched; halfwords align down to an even lane
  function automatic logic [1:0] lane_offset(mem_len_e len, logic [1:0] adr_lo);
    case (len)
      LEN_BYTE: return adr_lo;
      LEN_HALF: return {adr_lo[1], 1'b0};
      default:  return 2'd0;
    endcase
  endfunction

  function automatic lane_t lane_mask(mem_len_e len, logic [1:0] off);
    case (len)
      LEN_BYTE: return lane_t'(4'b0001 << off);
      LEN_HALF: return lane_t'(4'b0011 << off);
      default:  return 4'b1111;
    endcase
  endfunction

endpackage

`default_nettype wire
